// File: logic/axi_defs.svh
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_RESP_W 2

// Address map of the non-SRAM targets
`define UART_TX_ADDR        32'ha00003f8
`define CLINT_CMP_LO_ADDR   32'h00002130
`define CLINT_CMP_HI_ADDR   32'h00002134
`define CLINT_MTIME_LO_ADDR 32'ha0000048

// SRAM words indexed by address bits 9:2
`define SRAM_WORDS 256

`endif

// File: logic/axi_pkg.sv
`include "axi_defs.svh"

package axi_pkg;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_RESP_W-1:0] resp;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_RESP_W-1:0] resp;
    } axi_b_t;

    // Master to slave
    typedef struct packed {
        axi_ar_t ar;
        logic    arvalid;
        logic    rready;
        axi_aw_t aw;
        logic    awvalid;
        axi_w_t  w;
        logic    wvalid;
        logic    bready;
    } axi_req_t;

    // Slave to master
    typedef struct packed {
        logic    arready;
        axi_r_t  r;
        logic    rvalid;
        logic    awready;
        logic    wready;
        axi_b_t  b;
        logic    bvalid;
    } axi_rsp_t;

    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_UART,
        SEL_CLINT
    } tgt_sel_e;

    localparam logic [`AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// File: logic/axi_arbiter.sv
`include "axi_defs.svh"

module axi_arbiter
    import axi_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  axi_req_t m0_req,
    output axi_rsp_t m0_rsp,
    input  axi_req_t m1_req,
    output axi_rsp_t m1_rsp,

    output axi_req_t bus_req,
    input  axi_rsp_t bus_rsp
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    arb_state_e state_q;
    logic       owner_q;
    logic       m0_any;
    logic       m1_any;
    logic       sel_m1;
    logic       active;
    logic       rsp_done;

    assign m0_any = m0_req.arvalid | m0_req.awvalid;
    assign m1_any = m1_req.arvalid | m1_req.awvalid;

    // m1 wins at idle, afterwards the registered owner holds
    assign sel_m1 = (state_q == ARB_BUSY) ? owner_q : m1_any;
    assign active = (state_q == ARB_BUSY) | m0_any | m1_any;

    always_comb begin
        bus_req = '0;
        m0_rsp  = '0;
        m1_rsp  = '0;
        if (active) begin
            if (sel_m1) begin
                bus_req = m1_req;
                m1_rsp  = bus_rsp;
            end else begin
                bus_req = m0_req;
                m0_rsp  = bus_rsp;
            end
        end
    end

    // Transaction ends on the owner's R or B handshake
    assign rsp_done = (bus_rsp.rvalid & bus_req.rready) |
                      (bus_rsp.bvalid & bus_req.bready);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ARB_IDLE;
            owner_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (m0_any | m1_any) begin
                        state_q <= ARB_BUSY;
                        owner_q <= m1_any;
                    end
                end
                ARB_BUSY: begin
                    if (rsp_done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/axi_xbar.sv
`include "axi_defs.svh"

module axi_xbar
    import axi_pkg::*;
(
    input  axi_req_t bus_req,
    output axi_rsp_t bus_rsp,

    output axi_req_t sram_req,
    input  axi_rsp_t sram_rsp,
    output axi_req_t uart_req,
    input  axi_rsp_t uart_rsp,
    output axi_req_t clint_req,
    input  axi_rsp_t clint_rsp
);

    tgt_sel_e         rd_sel;
    tgt_sel_e         wr_sel;
    axi_req_t [2:0]   tgt_req;
    axi_rsp_t [2:0]   tgt_rsp;

    function automatic tgt_sel_e decode(input logic [`AXI_ADDR_W-1:0] addr);
        tgt_sel_e sel;
        sel = SEL_SRAM;
        if (addr == `UART_TX_ADDR) begin
            sel = SEL_UART;
        end else if ((addr == `CLINT_CMP_LO_ADDR) ||
                     (addr == `CLINT_CMP_HI_ADDR) ||
                     (addr == `CLINT_MTIME_LO_ADDR)) begin
            sel = SEL_CLINT;
        end
        return sel;
    endfunction

    // Reads follow araddr, writes follow awaddr
    assign rd_sel = decode(bus_req.ar.addr);
    assign wr_sel = decode(bus_req.aw.addr);

    assign tgt_rsp[SEL_SRAM]  = sram_rsp;
    assign tgt_rsp[SEL_UART]  = uart_rsp;
    assign tgt_rsp[SEL_CLINT] = clint_rsp;

    assign sram_req  = tgt_req[SEL_SRAM];
    assign uart_req  = tgt_req[SEL_UART];
    assign clint_req = tgt_req[SEL_CLINT];

    always_comb begin
        tgt_req = '0;
        bus_rsp = '0;

        // AR and R
        tgt_req[rd_sel].ar      = bus_req.ar;
        tgt_req[rd_sel].arvalid = bus_req.arvalid;
        tgt_req[rd_sel].rready  = bus_req.rready;
        bus_rsp.arready         = tgt_rsp[rd_sel].arready;
        bus_rsp.r               = tgt_rsp[rd_sel].r;
        bus_rsp.rvalid          = tgt_rsp[rd_sel].rvalid;

        // AW, W and B
        tgt_req[wr_sel].aw      = bus_req.aw;
        tgt_req[wr_sel].awvalid = bus_req.awvalid;
        tgt_req[wr_sel].w       = bus_req.w;
        tgt_req[wr_sel].wvalid  = bus_req.wvalid;
        tgt_req[wr_sel].bready  = bus_req.bready;
        bus_rsp.awready         = tgt_rsp[wr_sel].awready;
        bus_rsp.wready          = tgt_rsp[wr_sel].wready;
        bus_rsp.b               = tgt_rsp[wr_sel].b;
        bus_rsp.bvalid          = tgt_rsp[wr_sel].bvalid;
    end

endmodule

// File: logic/axi_sram.sv
`include "axi_defs.svh"

module axi_sram
    import axi_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  axi_req_t req,
    output axi_rsp_t rsp
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    logic [`AXI_DATA_W-1:0] mem [0:`SRAM_WORDS-1];
    logic [`AXI_DATA_W-1:0] rdata_q;
    logic                   rvalid_q;
    logic                   bvalid_q;
    logic                   idle;
    logic                   ar_fire;
    logic                   wr_fire;
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;

    assign idle    = ~rvalid_q & ~bvalid_q;
    assign ar_fire = req.arvalid & idle;
    assign wr_fire = req.awvalid & req.wvalid & idle;
    assign rd_idx  = req.ar.addr[IDX_W+1:2];
    assign wr_idx  = req.aw.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= mem[rd_idx];
        end
        if (wr_fire) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (req.w.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= req.w.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.arready = idle;
        rsp.r.data  = rdata_q;
        rsp.r.resp  = AXI_RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.awready = wr_fire;
        rsp.wready  = wr_fire;
        rsp.b.resp  = AXI_RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

endmodule

// File: logic/axi_uart_tx.sv
`include "axi_defs.svh"

module axi_uart_tx
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axi_req_t   req,
    output axi_rsp_t   rsp,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    logic       rvalid_q;
    logic       bvalid_q;
    logic       tx_valid_q;
    logic [7:0] last_byte_q;
    logic       idle;
    logic       ar_fire;
    logic       wr_fire;

    assign idle    = ~rvalid_q & ~bvalid_q;
    assign ar_fire = req.arvalid & idle;
    assign wr_fire = req.awvalid & req.wvalid & idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q    <= 1'b0;
            bvalid_q    <= 1'b0;
            tx_valid_q  <= 1'b0;
            last_byte_q <= 8'h00;
        end else begin
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
            // Only byte lane 0 reaches the transmitter
            tx_valid_q <= wr_fire & req.w.strb[0];
            if (wr_fire && req.w.strb[0]) begin
                last_byte_q <= req.w.data[7:0];
            end
        end
    end

    assign tx_valid = tx_valid_q;
    assign tx_data  = last_byte_q;

    always_comb begin
        rsp         = '0;
        rsp.arready = idle;
        rsp.r.data  = {{(`AXI_DATA_W-8){1'b0}}, last_byte_q};
        rsp.r.resp  = AXI_RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.awready = wr_fire;
        rsp.wready  = wr_fire;
        rsp.b.resp  = AXI_RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

endmodule

// File: logic/axi_clint.sv
`include "axi_defs.svh"

module axi_clint
    import axi_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  axi_req_t req,
    output axi_rsp_t rsp,
    output logic     timer_irq
);

    logic [63:0]            mtime_q;
    logic [63:0]            mtimecmp_q;
    logic [`AXI_DATA_W-1:0] rdata_q;
    logic                   rvalid_q;
    logic                   bvalid_q;
    logic                   irq_q;
    logic                   idle;
    logic                   ar_fire;
    logic                   wr_fire;

    function automatic logic [31:0] merge(input logic [31:0] old_word,
                                          input logic [31:0] new_word,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idle    = ~rvalid_q & ~bvalid_q;
    assign ar_fire = req.arvalid & idle;
    assign wr_fire = req.awvalid & req.wvalid & idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
            rvalid_q   <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            irq_q   <= (mtime_q >= mtimecmp_q);
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
            // mtime itself is read-only, writes there just complete
            if (wr_fire && req.aw.addr == `CLINT_CMP_LO_ADDR) begin
                mtimecmp_q[31:0] <= merge(mtimecmp_q[31:0], req.w.data, req.w.strb);
            end
            if (wr_fire && req.aw.addr == `CLINT_CMP_HI_ADDR) begin
                mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], req.w.data, req.w.strb);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            case (req.ar.addr)
                `CLINT_CMP_LO_ADDR: rdata_q <= mtimecmp_q[31:0];
                `CLINT_CMP_HI_ADDR: rdata_q <= mtimecmp_q[63:32];
                default:            rdata_q <= mtime_q[31:0];
            endcase
        end
    end

    assign timer_irq = irq_q;

    always_comb begin
        rsp         = '0;
        rsp.arready = idle;
        rsp.r.data  = rdata_q;
        rsp.r.resp  = AXI_RESP_OKAY;
        rsp.rvalid  = rvalid_q;
        rsp.awready = wr_fire;
        rsp.wready  = wr_fire;
        rsp.b.resp  = AXI_RESP_OKAY;
        rsp.bvalid  = bvalid_q;
    end

endmodule

// File: logic/axi_soc.sv
`include "axi_defs.svh"

module axi_soc
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axi_req_t   m0_req,
    output axi_rsp_t   m0_rsp,
    input  axi_req_t   m1_req,
    output axi_rsp_t   m1_rsp,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    output logic       timer_irq
);

    axi_req_t bus_req;
    axi_rsp_t bus_rsp;
    axi_req_t sram_req;
    axi_rsp_t sram_rsp;
    axi_req_t uart_req;
    axi_rsp_t uart_rsp;
    axi_req_t clint_req;
    axi_rsp_t clint_rsp;

    axi_arbiter u_axi_arbiter (
        .clk     (clk),
        .reset   (reset),
        .m0_req  (m0_req),
        .m0_rsp  (m0_rsp),
        .m1_req  (m1_req),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    // Decode stage
    axi_xbar u_axi_xbar (
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .uart_req  (uart_req),
        .uart_rsp  (uart_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp)
    );

    // Targets
    axi_sram u_axi_sram (
        .clk   (clk),
        .reset (reset),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    axi_uart_tx u_axi_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .tx_valid (tx_valid),
        .tx_data  (tx_data)
    );

    axi_clint u_axi_clint (
        .clk       (clk),
        .reset     (reset),
        .req       (clint_req),
        .rsp       (clint_rsp),
        .timer_irq (timer_irq)
    );

endmodule

// File: verif/axi_soc_tb.sv
`include "axi_defs.svh"

module axi_soc_tb
    import axi_pkg::*;
();

    logic       clk;
    logic       reset;
    axi_req_t   mreq [2];
    axi_rsp_t   mrsp [2];
    axi_rsp_t   m0_rsp;
    axi_rsp_t   m1_rsp;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       timer_irq;

    // Reference state
    logic [31:0] shadow_mem [0:`SRAM_WORDS-1];
    logic [7:0]  uart_byte = 8'h00;
    logic [63:0] cmp_model = '1;
    logic [63:0] mtime_model;
    logic [31:0] exp_rdata [2];
    logic        irq_next;
    logic        irq_exp;
    logic        tx_next;
    logic        tx_exp;
    int          tx_seen = 0;
    int          issued = 0;
    time         done_time [2];

    axi_soc u_axi_soc (
        .clk       (clk),
        .reset     (reset),
        .m0_req    (mreq[0]),
        .m0_rsp    (m0_rsp),
        .m1_req    (mreq[1]),
        .m1_rsp    (m1_rsp),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .timer_irq (timer_irq)
    );

    assign mrsp[0] = m0_rsp;
    assign mrsp[1] = m1_rsp;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL time=%0t signal=%s expected=0x%h actual=0x%h",
                 $time, name, expected, actual);
        end_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        end_with_failure();
    endtask

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Expected read data for any address on the map
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (addr == `UART_TX_ADDR) begin
            return {24'h0, uart_byte};
        end
        if (addr == `CLINT_CMP_LO_ADDR) begin
            return cmp_model[31:0];
        end
        if (addr == `CLINT_CMP_HI_ADDR) begin
            return cmp_model[63:32];
        end
        if (addr == `CLINT_MTIME_LO_ADDR) begin
            return mtime_model[31:0];
        end
        return shadow_mem[addr[9:2]];
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        if (addr == `UART_TX_ADDR) begin
            if (strb[0]) begin
                uart_byte = data[7:0];
            end
        end else if (addr == `CLINT_CMP_LO_ADDR) begin
            cmp_model[31:0] = apply_strobes(cmp_model[31:0], data, strb);
        end else if (addr == `CLINT_CMP_HI_ADDR) begin
            cmp_model[63:32] = apply_strobes(cmp_model[63:32], data, strb);
        end else if (addr != `CLINT_MTIME_LO_ADDR) begin
            shadow_mem[addr[9:2]] = apply_strobes(shadow_mem[addr[9:2]], data, strb);
        end
    endfunction

    // Model mtime ticks every cycle
    // Irq and tx pulse lag their cause by one edge
    always @(posedge clk) begin
        if (reset) begin
            mtime_model <= '0;
            irq_exp     <= 1'b0;
            tx_exp      <= 1'b0;
        end else begin
            mtime_model <= mtime_model + 64'd1;
            irq_exp     <= irq_next;
            tx_exp      <= tx_next;
        end
    end

    // Compare process sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            assert (timer_irq === irq_exp)
                else report_mismatch("timer_irq", 32'(irq_exp), 32'(timer_irq));
            assert (tx_valid === tx_exp)
                else report_mismatch("tx_valid", 32'(tx_exp), 32'(tx_valid));
            if (tx_valid) begin
                tx_seen++;
                assert (tx_data === uart_byte)
                    else report_mismatch("tx_data", 32'(uart_byte), 32'(tx_data));
            end
        end
        irq_next = (mtime_model >= cmp_model);
        tx_next  = 1'b0;
        for (int m = 0; m < 2; m++) begin
            if (mrsp[m].rvalid && mreq[m].rready) begin
                assert (mrsp[m].r.data === exp_rdata[m])
                    else report_mismatch($sformatf("m%0d_rsp.r.data", m),
                                         exp_rdata[m], mrsp[m].r.data);
                assert (mrsp[m].r.resp === 2'b00)
                    else report_mismatch($sformatf("m%0d_rsp.r.resp", m),
                                         32'd0, 32'(mrsp[m].r.resp));
            end
            if (mrsp[m].bvalid && mreq[m].bready) begin
                assert (mrsp[m].b.resp === 2'b00)
                    else report_mismatch($sformatf("m%0d_rsp.b.resp", m),
                                         32'd0, 32'(mrsp[m].b.resp));
            end
            if (mreq[m].arvalid && mrsp[m].arready) begin
                exp_rdata[m] = model_read(mreq[m].ar.addr);
            end
            if (mreq[m].awvalid && mreq[m].wvalid && mrsp[m].awready && mrsp[m].wready) begin
                if (mreq[m].aw.addr == `UART_TX_ADDR && mreq[m].w.strb[0]) begin
                    tx_next = 1'b1;
                end
                model_write(mreq[m].aw.addr, mreq[m].w.data, mreq[m].w.strb);
            end
        end
    end

    // Watchdog budget grows with every issued transaction
    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > issued * 40 + 200) begin
                report_error($sformatf("simulation timed out after %0d cycles", cycles));
            end
        end
    end

    task automatic axi_read(input int m, input logic [31:0] addr, input int stall,
                            input bit check_lat, output logic [31:0] rdata);
        int          waited;
        logic [31:0] held;
        issued++;
        @(posedge clk);
        #1;
        mreq[m].ar.addr = addr;
        mreq[m].arvalid = 1'b1;
        mreq[m].rready  = (stall == 0);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mrsp[m].arready);
        @(posedge clk);
        #1;
        mreq[m].arvalid = 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mrsp[m].rvalid);
        if (check_lat) begin
            assert (waited == 2)
                else report_mismatch($sformatf("m%0d read latency", m), 32'd2, 32'(waited));
        end
        if (stall > 0) begin
            held = mrsp[m].r.data;
            repeat (stall) begin
                @(negedge clk);
                assert (mrsp[m].rvalid)
                    else report_error($sformatf("m%0d rvalid dropped before rready", m));
                assert (mrsp[m].r.data === held)
                    else report_mismatch($sformatf("m%0d_rsp.r.data", m), held, mrsp[m].r.data);
            end
            @(posedge clk);
            #1;
            mreq[m].rready = 1'b1;
            @(negedge clk);
        end
        rdata = mrsp[m].r.data;
        done_time[m] = $time;
        @(posedge clk);
        #1;
        mreq[m].rready = 1'b0;
    endtask

    task automatic axi_write(input int m, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall, input bit check_lat);
        int         waited;
        logic [1:0] held;
        issued++;
        @(posedge clk);
        #1;
        mreq[m].aw.addr = addr;
        mreq[m].w.data  = data;
        mreq[m].w.strb  = strb;
        mreq[m].awvalid = 1'b1;
        mreq[m].wvalid  = 1'b1;
        mreq[m].bready  = (stall == 0);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(mrsp[m].awready && mrsp[m].wready));
        @(posedge clk);
        #1;
        mreq[m].awvalid = 1'b0;
        mreq[m].wvalid  = 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mrsp[m].bvalid);
        if (check_lat) begin
            assert (waited == 2)
                else report_mismatch($sformatf("m%0d write latency", m), 32'd2, 32'(waited));
        end
        if (stall > 0) begin
            held = mrsp[m].b.resp;
            repeat (stall) begin
                @(negedge clk);
                assert (mrsp[m].bvalid)
                    else report_error($sformatf("m%0d bvalid dropped before bready", m));
                assert (mrsp[m].b.resp === held)
                    else report_mismatch($sformatf("m%0d_rsp.b.resp", m),
                                         32'(held), 32'(mrsp[m].b.resp));
            end
            @(posedge clk);
            #1;
            mreq[m].bready = 1'b1;
            @(negedge clk);
        end
        done_time[m] = $time;
        @(posedge clk);
        #1;
        mreq[m].bready = 1'b0;
    endtask

    initial begin
        logic [31:0] addrs [8];
        logic [31:0] data;
        logic [31:0] data1;
        logic [31:0] first;
        logic [31:0] second;
        int          waited;
        void'($urandom(32'h0c1f968e));
        reset   = 1'b1;
        mreq[0] = '0;
        mreq[1] = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle outputs after reset
        @(negedge clk);
        for (int m = 0; m < 2; m++) begin
            assert (!mrsp[m].rvalid && !mrsp[m].bvalid && !mrsp[m].arready && !mrsp[m].awready)
                else report_error($sformatf("m%0d response signals not idle after reset", m));
        end
        assert (!tx_valid && !timer_irq)
            else report_error("tx_valid or timer_irq high after reset");

        // SRAM with random strobes from both masters
        for (int k = 0; k < 8; k++) begin
            addrs[k] = $urandom & 32'h0000_03fc;
            axi_write(k % 2, addrs[k], $urandom, 4'hf, 0, 1'b1);
            axi_write((k + 1) % 2, addrs[k], $urandom, 4'($urandom), 0, 1'b1);
        end
        // Unmapped high address aliases onto index 0x97
        axi_write(1, 32'h8000_0a5c, 32'h1357_9bdf, 4'hf, 0, 1'b1);
        for (int k = 0; k < 8; k++) begin
            axi_read(k % 2, addrs[k], 0, 1'b1, data);
        end
        axi_read(0, 32'h0000_025c, 0, 1'b1, data);

        // UART transmit
        axi_write(1, `UART_TX_ADDR, $urandom, 4'h1, 0, 1'b1);
        axi_read(0, `UART_TX_ADDR, 0, 1'b1, data);
        axi_write(0, `UART_TX_ADDR, 32'h1234_56a5, 4'he, 0, 1'b1);
        axi_read(1, `UART_TX_ADDR, 0, 1'b1, data);
        repeat (3) @(negedge clk);
        assert (tx_seen == 1)
            else report_mismatch("tx_valid pulse count", 32'd1, 32'(tx_seen));

        // Timer
        axi_read(1, `CLINT_MTIME_LO_ADDR, 0, 1'b1, first);
        axi_read(0, `CLINT_MTIME_LO_ADDR, 0, 1'b1, second);
        assert (second > first)
            else report_error("mtime did not increase between two reads");
        axi_write(1, `CLINT_CMP_LO_ADDR, first + 32'd100, 4'hf, 0, 1'b1);
        axi_write(1, `CLINT_CMP_HI_ADDR, 32'h0, 4'hf, 0, 1'b1);
        @(negedge clk);
        assert (!timer_irq)
            else report_mismatch("timer_irq", 32'd0, 32'(timer_irq));
        waited = 0;
        while (!timer_irq && waited < 120) begin
            @(negedge clk);
            waited++;
        end
        assert (timer_irq)
            else report_error("timer_irq did not rise within 120 cycles");

        // Same-cycle requests where m1 wins
        fork
            axi_read(0, addrs[0], 0, 1'b0, data);
            axi_read(1, addrs[1], 0, 1'b0, data1);
        join
        assert (done_time[1] < done_time[0])
            else report_error("m0 response completed before m1 response");

        // Back-pressure on R and B
        for (int k = 0; k < 4; k++) begin
            axi_write(k % 2, addrs[k], $urandom, 4'hf, $urandom_range(8, 1), 1'b0);
            axi_read((k + 1) % 2, addrs[k], $urandom_range(8, 1), 1'b0, data);
        end

        repeat (2) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: axi_soc.f
+incdir+logic
logic/axi_pkg.sv
logic/axi_arbiter.sv
logic/axi_xbar.sv
logic/axi_sram.sv
logic/axi_uart_tx.sv
logic/axi_clint.sv
logic/axi_soc.sv
verif/axi_soc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module axi_soc_tb \
    -f axi_soc.f \
    --Mdir obj_dir \
    -o axi_soc_sim

./obj_dir/axi_soc_sim
